//--- Bender.yml
package:
  name: div_queue

sources:
  - files:
      - div_pkg.sv
      - div_request_capture.sv
      - div_request_fifo.sv
      - div_datapath.sv
      - div_sequencer.sv
      - div_top.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - div_props.sv
      - div_tb.sv

//--- div_datapath.sv
`timescale 1ns/100ps

module div_datapath (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          load,
    input  logic                          step,
    input  logic                          clear,
    input  logic [div_pkg::div_width-1:0] dividend,
    input  logic [div_pkg::div_width-1:0] divisor,
    output logic [div_pkg::step_w-1:0]    step_count,
    output logic [div_pkg::div_width-1:0] quotient,
    output logic [div_pkg::div_width-1:0] remainder
);

    logic [div_pkg::acc_width-1:0] divisor_r;
    logic [div_pkg::div_width-1:0] quo_r;
    logic [div_pkg::acc_width-1:0] acc_r;
    logic [div_pkg::acc_width-1:0] shifted;
    logic [div_pkg::acc_width-1:0] diff;
    logic                          negative;
    logic [div_pkg::acc_width-1:0] acc_next;
    logic [div_pkg::div_width-1:0] quo_next;

    // divisor held for the whole division
    always_ff @(posedge clk) begin
        if (load) begin
            divisor_r <= {1'b0, divisor};       // guard bit clear
        end
    end

    // partial remainder shifted left with the next dividend bit at the bottom
    assign shifted = {acc_r[div_pkg::div_width-1:0], quo_r[div_pkg::div_width-1]};

    assign diff = shifted - divisor_r;

    // guard bit set means the trial subtract went below zero
    assign negative = diff[div_pkg::acc_width-1];

    // restore on a negative result
    always_comb begin
        if (negative) begin
            acc_next = shifted;
        end else begin
            acc_next = diff;
        end
    end

    assign quo_next = {quo_r[div_pkg::div_width-2:0], ~negative};

    // quotient bits shift in behind the dividend
    always_ff @(posedge clk) begin
        if (load) begin
            quo_r <= dividend;
        end else if (step) begin
            quo_r <= quo_next;
        end
    end

    always_ff @(posedge clk) begin
        if (load || clear) begin
            acc_r <= '0;
        end else if (step) begin
            acc_r <= acc_next;
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            step_count <= '0;
        end else if (load || clear) begin
            step_count <= '0;
        end else if (step) begin
            step_count <= step_count + 1'b1;    // div_width after last step
        end
    end

    assign quotient = quo_r;
    assign remainder = acc_r[div_pkg::div_width-1:0];   // guard bit is zero here

endmodule

//--- div_pkg.sv
package div_pkg;

    // operand and result width
    localparam int div_width = 16;

    // partial remainder plus one guard bit
    localparam int acc_width = div_width + 1;

    localparam int step_w = 5;          // counts 0 .. div_width
    localparam int tag_w = 4;           // wraps modulo 16

    localparam int fifo_depth = 4;
    localparam int fifo_ptr_w = 2;

    // request word {dividend, divisor, zero flag, tag}
    localparam int entry_w = 2 * div_width + 1 + tag_w;

    // field positions inside a request word
    localparam int zero_bit = tag_w;
    localparam int divisor_lsb = zero_bit + 1;
    localparam int dividend_lsb = divisor_lsb + div_width;

    // sequencer FSM encoding
    localparam logic [1:0] seq_idle = 2'd0;
    localparam logic [1:0] seq_run = 2'd1;
    localparam logic [1:0] seq_finish = 2'd2;

endpackage

//--- div_props.sv
`timescale 1ns/100ps

module div_props (
    input logic                       clk,
    input logic                       reset,
    input logic                       pop,
    input logic                       load,
    input logic                       head_zero,
    input logic                       step,
    input logic [div_pkg::step_w-1:0] step_count,
    input logic                       res_valid,
    input logic                       res_div_zero
);

    int n_fail = 0;

    // datapath back at step zero before it takes a new request
    pop_on_cleared_datapath: assert property (
        @(posedge clk) disable iff (!reset) pop |-> step_count == '0
    ) else begin
        n_fail++;
        $error("sequencer popped while the datapath was not cleared");
    end

    // one quotient bit per step, then the finish cycle
    step_run_length: assert property (
        @(posedge clk) disable iff (!reset)
        load && !head_zero |=> step [*div_pkg::div_width] ##1 (!step && res_valid)
    ) else begin
        n_fail++;
        $error("step run length differs from the operand width");
    end

    res_after_last_step: assert property (
        @(posedge clk) disable iff (!reset)
        res_valid && !res_div_zero |-> step_count == div_pkg::step_w'(div_pkg::div_width)
    ) else begin
        n_fail++;
        $error("result strobe before the last quotient bit");
    end

    zero_skips_steps: assert property (
        @(posedge clk) disable iff (!reset)
        load && head_zero |=> res_valid && step_count == '0
    ) else begin
        n_fail++;
        $error("zero divisor request entered the iteration");
    end

endmodule

bind div_sequencer div_props u_props (
    .clk          (clk),
    .reset        (reset),
    .pop          (pop),
    .load         (load),
    .head_zero    (head_zero),
    .step         (step),
    .step_count   (step_count),
    .res_valid    (res_valid),
    .res_div_zero (res_div_zero)
);

//--- div_request_capture.sv
`timescale 1ns/100ps

module div_request_capture (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          req_valid,
    input  logic [div_pkg::div_width-1:0] req_dividend,
    input  logic [div_pkg::div_width-1:0] req_divisor,
    input  logic                          full,
    output logic                          push,
    output logic [div_pkg::entry_w-1:0]   push_entry,
    output logic                          req_accepted,
    output logic                          req_dropped,
    output logic [div_pkg::tag_w-1:0]     req_tag
);

    logic                          req_q;
    logic [div_pkg::div_width-1:0] dividend_q;
    logic [div_pkg::div_width-1:0] divisor_q;
    logic                          zero_q;
    logic [div_pkg::tag_w-1:0]     tag_cnt;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            req_q <= 1'b0;
        end else begin
            req_q <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid) begin
            dividend_q <= req_dividend;
            divisor_q <= req_divisor;
            zero_q <= (req_divisor == '0);      // divide by zero flag
        end
    end

    // full is looked at in the push cycle
    assign push = req_q && !full;
    assign req_dropped = req_q && full;
    assign req_accepted = push;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            tag_cnt <= '0;
        end else if (push) begin
            tag_cnt <= tag_cnt + 1'b1;          // drops keep the tag
        end
    end

    assign push_entry = {dividend_q, divisor_q, zero_q, tag_cnt};
    assign req_tag = tag_cnt;                   // tag of this cycle's accept

endmodule

//--- div_request_fifo.sv
`timescale 1ns/100ps

module div_request_fifo (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        push,
    input  logic [div_pkg::entry_w-1:0] push_entry,
    input  logic                        pop,
    output logic [div_pkg::entry_w-1:0] head_entry,
    output logic                        empty,
    output logic                        full
);

    logic [div_pkg::entry_w-1:0]    mem [div_pkg::fifo_depth];
    logic [div_pkg::fifo_ptr_w-1:0] wr_ptr;
    logic [div_pkg::fifo_ptr_w-1:0] rd_ptr;
    logic [div_pkg::fifo_ptr_w:0]   count;
    logic                           do_push;
    logic                           do_pop;

    assign empty = (count == '0);
    assign full = (count == (div_pkg::fifo_ptr_w + 1)'(div_pkg::fifo_depth));

    assign do_push = push && !full;             // push on full is lost
    assign do_pop = pop && !empty;

    assign head_entry = mem[rd_ptr];            // valid while not empty

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_entry;
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            wr_ptr <= '0;
        end else if (do_push) begin
            wr_ptr <= wr_ptr + 1'b1;            // wraps at depth
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            rd_ptr <= '0;
        end else if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // both strobes together leave the occupancy unchanged
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            count <= '0;
        end else begin
            case ({do_push, do_pop})
                2'b10: begin
                    count <= count + 1'b1;
                end
                2'b01: begin
                    count <= count - 1'b1;
                end
                default: begin
                    count <= count;
                end
            endcase
        end
    end

endmodule

//--- div_sequencer.sv
`timescale 1ns/100ps

module div_sequencer (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          empty,
    input  logic [div_pkg::entry_w-1:0]   head_entry,
    output logic                          pop,
    output logic                          res_valid,
    output logic [div_pkg::tag_w-1:0]     res_tag,
    output logic [div_pkg::div_width-1:0] res_quotient,
    output logic [div_pkg::div_width-1:0] res_remainder,
    output logic                          res_div_zero
);

    logic [1:0]                    state;
    logic [1:0]                    state_next;
    logic                          load;
    logic                          step;
    logic                          clear;
    logic                          head_zero;
    logic [div_pkg::tag_w-1:0]     tag_q;
    logic                          zero_q;
    logic [div_pkg::step_w-1:0]    step_count;
    logic [div_pkg::div_width-1:0] dp_quotient;
    logic [div_pkg::div_width-1:0] dp_remainder;

    assign head_zero = head_entry[div_pkg::zero_bit];

    div_datapath u_datapath (
        .clk        (clk),
        .reset      (reset),
        .load       (load),
        .step       (step),
        .clear      (clear),
        .dividend   (head_entry[div_pkg::dividend_lsb +: div_pkg::div_width]),
        .divisor    (head_entry[div_pkg::divisor_lsb +: div_pkg::div_width]),
        .step_count (step_count),
        .quotient   (dp_quotient),
        .remainder  (dp_remainder)
    );

    assign pop = (state == div_pkg::seq_idle) && !empty;
    assign load = pop;                          // same cycle as pop
    assign step = (state == div_pkg::seq_run);
    assign clear = (state == div_pkg::seq_finish);

    always_comb begin
        state_next = state;
        case (state)
            div_pkg::seq_idle: begin
                if (!empty) begin
                    state_next = head_zero ? div_pkg::seq_finish : div_pkg::seq_run;
                end
            end
            div_pkg::seq_run: begin
                // this step writes the last quotient bit
                if (step_count == div_pkg::step_w'(div_pkg::div_width - 1)) begin
                    state_next = div_pkg::seq_finish;
                end
            end
            default: begin
                state_next = div_pkg::seq_idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state <= div_pkg::seq_idle;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            tag_q <= head_entry[div_pkg::tag_w-1:0];
            zero_q <= head_zero;
        end
    end

    // finish cycle reads the datapath registers directly
    assign res_valid = (state == div_pkg::seq_finish);
    assign res_tag = tag_q;
    assign res_div_zero = zero_q;
    assign res_quotient = zero_q ? '1 : dp_quotient;
    assign res_remainder = zero_q ? dp_quotient : dp_remainder;   // still the dividend

endmodule

//--- div_tb.sv
`timescale 1ns/100ps

module div_tb;

    localparam int w = div_pkg::div_width;
    localparam int tags = 2 ** div_pkg::tag_w;
    localparam int burst_len = div_pkg::fifo_depth + 4;
    localparam int stream_len = 40;
    localparam int n_requests = 2 + 7 + div_pkg::fifo_depth + burst_len + stream_len;
    localparam int watchdog_cycles = n_requests * (w + 3) * div_pkg::fifo_depth + 2000;
    localparam int drain_limit = (div_pkg::fifo_depth + 2) * (w + 3);

    logic                      clk;
    logic                      reset;
    logic                      req_valid;
    logic [w-1:0]              req_dividend;
    logic [w-1:0]              req_divisor;
    logic                      req_accepted;
    logic [div_pkg::tag_w-1:0] req_tag;
    logic                      req_dropped;
    logic                      res_valid;
    logic [div_pkg::tag_w-1:0] res_tag;
    logic [w-1:0]              res_quotient;
    logic [w-1:0]              res_remainder;
    logic                      res_div_zero;

    // requests driven but not yet seen as accepted or dropped
    logic [w-1:0] iss_dividend [$];
    logic [w-1:0] iss_divisor [$];
    bit           iss_check [$];
    bit           iss_drop [$];

    logic [w-1:0]              exp_quotient [tags];
    logic [w-1:0]              exp_remainder [tags];
    bit                        exp_zero [tags];
    logic [div_pkg::tag_w-1:0] order_q [$];     // tags in request order
    logic [div_pkg::tag_w-1:0] next_tag;
    int                        n_dropped;

    tb_clock_gen u_clk (
        .clk (clk)
    );

    div_top dut (
        .clk           (clk),
        .reset         (reset),
        .req_valid     (req_valid),
        .req_dividend  (req_dividend),
        .req_divisor   (req_divisor),
        .req_accepted  (req_accepted),
        .req_tag       (req_tag),
        .req_dropped   (req_dropped),
        .res_valid     (res_valid),
        .res_tag       (res_tag),
        .res_quotient  (res_quotient),
        .res_remainder (res_remainder),
        .res_div_zero  (res_div_zero)
    );

    function automatic logic [w-1:0] ref_quotient(input logic [w-1:0] a, input logic [w-1:0] b);
        if (b == '0) begin
            return '1;
        end
        return a / b;
    endfunction

    function automatic logic [w-1:0] ref_remainder(input logic [w-1:0] a, input logic [w-1:0] b);
        if (b == '0) begin
            return a;
        end
        return a % b;
    endfunction

    task automatic stop_on_failure();
        $display("TEST FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("[FAIL] %s: got %h expected %h", name, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_true(input bit cond, input string what);
        assert (cond) else begin
            $display("%s", what);
            stop_on_failure();
        end
    endtask

    task automatic record_capture();
        logic [w-1:0] a;
        logic [w-1:0] b;
        bit           chk;
        bit           drp;
        check_true(iss_dividend.size() > 0, "request strobe seen with no request issued");
        check_true(!(req_accepted && req_dropped), "req_accepted and req_dropped high together");
        a = iss_dividend.pop_front();
        b = iss_divisor.pop_front();
        chk = iss_check.pop_front();
        drp = iss_drop.pop_front();
        if (chk) begin
            check_value("req_dropped", req_dropped, drp);
        end
        if (req_dropped) begin
            n_dropped++;                        // no tag used
        end else begin
            check_value("req_tag", req_tag, next_tag);
            exp_quotient[next_tag] = ref_quotient(a, b);
            exp_remainder[next_tag] = ref_remainder(a, b);
            exp_zero[next_tag] = (b == '0);
            order_q.push_back(next_tag);
            next_tag++;
        end
    endtask

    task automatic record_result();
        logic [div_pkg::tag_w-1:0] tag;
        check_true(order_q.size() > 0, "result strobe with no request outstanding");
        tag = order_q.pop_front();
        check_value("res_tag", res_tag, tag);
        check_value("res_quotient", res_quotient, exp_quotient[tag]);
        check_value("res_remainder", res_remainder, exp_remainder[tag]);
        check_value("res_div_zero", res_div_zero, exp_zero[tag]);
    endtask

    always @(negedge clk) begin
        if (reset) begin
            if (req_accepted || req_dropped) begin
                record_capture();
            end
            if (res_valid) begin
                record_result();
            end
        end
    end

    task automatic issue_request(input logic [w-1:0] a, input logic [w-1:0] b,
                                 input bit chk, input bit drp);
        @(posedge clk);
        req_valid <= 1'b1;
        req_dividend <= a;
        req_divisor <= b;
        iss_dividend.push_back(a);
        iss_divisor.push_back(b);
        iss_check.push_back(chk);
        iss_drop.push_back(drp);
    endtask

    task automatic release_request();
        @(posedge clk);
        req_valid <= 1'b0;
    endtask

    task automatic drain();
        int n;
        n = 0;
        while ((order_q.size() > 0 || iss_dividend.size() > 0) && n < drain_limit) begin
            @(negedge clk);
            n++;
        end
        check_true(order_q.size() == 0 && iss_dividend.size() == 0,
                   "results did not drain within the time limit");
        repeat (2) @(posedge clk);
    endtask

    // counts cycles from the request cycle to res_valid
    task automatic measure_latency(output int cycles, output logic [div_pkg::tag_w-1:0] tag_seen);
        cycles = 0;
        tag_seen = '0;
        do begin
            @(posedge clk);
            req_valid <= 1'b0;
            @(negedge clk);
            cycles++;
            if (req_accepted) begin
                tag_seen = req_tag;
            end
        end while (!res_valid && cycles < drain_limit);
        check_true(res_valid, "no result strobe within the time limit");
    endtask

    task automatic single_request_latency();
        logic [w-1:0]              a;
        logic [w-1:0]              b;
        int                        cycles;
        logic [div_pkg::tag_w-1:0] tag;
        a = w'($urandom_range(16'hffff, 1));
        b = w'($urandom_range(16'h00ff, 1));
        issue_request(a, b, 1'b1, 1'b0);
        measure_latency(cycles, tag);
        check_value("res_valid latency", cycles, w + 3);
        check_value("res_tag", res_tag, tag);
        check_value("res_quotient", res_quotient, a / b);
        check_value("res_remainder", res_remainder, a % b);
        drain();
    endtask

    task automatic zero_divisor_result();
        logic [w-1:0]              a;
        int                        cycles;
        logic [div_pkg::tag_w-1:0] tag;
        a = w'($urandom_range(16'hffff, 0));
        issue_request(a, '0, 1'b1, 1'b0);
        measure_latency(cycles, tag);
        check_value("res_valid latency", cycles, 3);
        check_value("res_div_zero", res_div_zero, 1'b1);
        check_value("res_quotient", res_quotient, 16'hffff);
        check_value("res_remainder", res_remainder, a);
        drain();
    endtask

    task automatic edge_operands();
        logic [w-1:0] a_list [7] = '{16'h0000, 16'h1234, 16'h0abc, 16'h0007,
                                     16'hffff, 16'hffff, 16'h0001};
        logic [w-1:0] b_list [7] = '{16'h0005, 16'h0001, 16'h0abc, 16'h0300,
                                     16'hffff, 16'h0001, 16'hffff};
        for (int i = 0; i < 7; i++) begin
            issue_request(a_list[i], b_list[i], 1'b1, 1'b0);
            release_request();
            drain();
        end
    endtask

    task automatic queued_burst();
        for (int i = 0; i < div_pkg::fifo_depth; i++) begin
            issue_request(w'($urandom_range(16'hffff, 0)), w'($urandom_range(16'h0fff, 1)),
                          1'b1, 1'b0);
        end
        release_request();
        drain();
    endtask

    // one request in service and fifo_depth queued before drops start
    task automatic overflow_drop();
        int drops_before;
        drops_before = n_dropped;
        for (int i = 0; i < burst_len; i++) begin
            issue_request(w'($urandom_range(16'hffff, 0)), w'($urandom_range(16'hffff, 1)),
                          1'b1, i > div_pkg::fifo_depth);
        end
        release_request();
        drain();
        check_value("req_dropped count", n_dropped - drops_before,
                    burst_len - div_pkg::fifo_depth - 1);
    endtask

    task automatic random_stream();
        logic [w-1:0] a;
        logic [w-1:0] b;
        int           gap;
        for (int i = 0; i < stream_len; i++) begin
            a = w'($urandom);
            case ($urandom_range(7, 0))
                0: b = '0;
                1, 2, 3: b = w'($urandom_range(255, 1));
                default: b = w'($urandom_range(16'hffff, 1));
            endcase
            gap = $urandom_range(24, 0);
            issue_request(a, b, 1'b0, 1'b0);    // drops not predicted here
            if (gap > 0) begin
                release_request();
                repeat (gap - 1) @(posedge clk);
            end
        end
        release_request();
        drain();
    endtask

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("watchdog expired before the tests finished");
        stop_on_failure();
    end

    initial begin
        void'($urandom(32'h1a598b35));
        reset <= 1'b0;
        req_valid <= 1'b0;
        req_dividend <= '0;
        req_divisor <= '0;
        next_tag = '0;
        n_dropped = 0;
        repeat (2) @(posedge clk);
        reset <= 1'b1;
        @(posedge clk);
        single_request_latency();
        zero_divisor_result();
        edge_operands();
        queued_burst();
        overflow_drop();
        random_stream();
        if (order_q.size() != 0 || iss_dividend.size() != 0) begin
            $display("expected results still outstanding at end of run");
            stop_on_failure();
        end else if (dut.u_sequencer.u_props.n_fail != 0) begin
            $display("a sequencer property failed during the run");
            stop_on_failure();
        end else begin
            $display("TEST PASSED");
            $finish;
        end
    end

endmodule

//--- div_top.sv
`timescale 1ns/100ps

module div_top (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          req_valid,
    input  logic [div_pkg::div_width-1:0] req_dividend,
    input  logic [div_pkg::div_width-1:0] req_divisor,
    output logic                          req_accepted,
    output logic [div_pkg::tag_w-1:0]     req_tag,
    output logic                          req_dropped,
    output logic                          res_valid,
    output logic [div_pkg::tag_w-1:0]     res_tag,
    output logic [div_pkg::div_width-1:0] res_quotient,
    output logic [div_pkg::div_width-1:0] res_remainder,
    output logic                          res_div_zero
);

    logic                        push;
    logic [div_pkg::entry_w-1:0] push_entry;
    logic                        full;
    logic                        pop;
    logic [div_pkg::entry_w-1:0] head_entry;
    logic                        empty;

    div_request_capture u_capture (
        .clk          (clk),
        .reset        (reset),
        .req_valid    (req_valid),
        .req_dividend (req_dividend),
        .req_divisor  (req_divisor),
        .full         (full),
        .push         (push),
        .push_entry   (push_entry),
        .req_accepted (req_accepted),
        .req_dropped  (req_dropped),
        .req_tag      (req_tag)
    );

    div_request_fifo u_fifo (
        .clk        (clk),
        .reset      (reset),
        .push       (push),
        .push_entry (push_entry),
        .pop        (pop),
        .head_entry (head_entry),
        .empty      (empty),
        .full       (full)
    );

    div_sequencer u_sequencer (
        .clk           (clk),
        .reset         (reset),
        .empty         (empty),
        .head_entry    (head_entry),
        .pop           (pop),
        .res_valid     (res_valid),
        .res_tag       (res_tag),
        .res_quotient  (res_quotient),
        .res_remainder (res_remainder),
        .res_div_zero  (res_div_zero)
    );

endmodule

//--- sim.f
div_pkg.sv
div_request_capture.sv
div_request_fifo.sv
div_datapath.sv
div_sequencer.sv
div_top.sv
tb_clock_gen.sv
div_props.sv
div_tb.sv

//--- tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen (
    output logic clk
);

    localparam int half_period = 20;    // 40 ns period

    initial begin
        clk = 1'b0;
        forever begin
            #half_period clk = ~clk;
        end
    end

endmodule
